// File: hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned CSR_ADDR_W = 12;

    // machine-mode csr addresses
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;

    // writable bits per register
    localparam logic [XLEN-1:0] MASK_MSTATUS = 32'h0000_1888; // mie, mpie, mpp
    localparam logic [XLEN-1:0] MASK_MIE     = 32'h0000_0888; // msie, mtie, meie
    localparam logic [XLEN-1:0] MASK_MIP     = 32'h0000_0000; // lines only
    localparam logic [XLEN-1:0] MASK_MTVEC   = 32'hFFFF_FFFC; // direct mode only
    localparam logic [XLEN-1:0] MASK_MEPC    = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MASK_FULL    = 32'hFFFF_FFFF;

    // mstatus fields
    localparam int unsigned BIT_MIE    = 3;
    localparam int unsigned BIT_MPIE   = 7;
    localparam int unsigned BIT_MPP_LO = 11; // mpp is two bits wide

    // mip / mie fields, also the interrupt cause codes
    localparam int unsigned BIT_MSIP = 3;
    localparam int unsigned BIT_MTIP = 7;
    localparam int unsigned BIT_MEIP = 11;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

endpackage

`default_nettype wire

// File: hdl/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // synchronous exception codes
    localparam logic [3:0] CAUSE_MISALIGNED_PC = 4'd0;
    localparam logic [3:0] CAUSE_ACCESS_FAULT  = 4'd1;
    localparam logic [3:0] CAUSE_ILLEGAL_INST  = 4'd2;
    localparam logic [3:0] CAUSE_BREAKPOINT    = 4'd3;
    localparam logic [3:0] CAUSE_ECALL_U       = 4'd8;
    localparam logic [3:0] CAUSE_ECALL_M       = 4'd11;

    // trap_id value when the core reports nothing
    localparam logic [4:0] CAUSE_NONE = 5'h1F;

    typedef enum logic [1:0] {
        EV_TRAP = 2'd0,
        EV_MRET = 2'd1
    } event_kind_t;

    // arbiter to register stage
    typedef struct packed {
        logic                      valid;
        event_kind_t               kind;
        logic                      is_interrupt;
        logic [3:0]                code;
        logic [csr_pkg::XLEN-1:0]  tval;
        logic [csr_pkg::XLEN-1:0]  epc;
    } trap_req_t;

    // one-cycle jump request to the fetch stage
    typedef struct packed {
        logic                      valid;
        logic [csr_pkg::XLEN-1:0]  pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: hdl/trap_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [csr_pkg::XLEN-1:0]   trap_pc,
    input  logic [csr_pkg::XLEN-1:0]   faulting_inst,
    input  logic [4:0]                 trap_id,
    input  logic                       ecall,
    input  logic                       mret,
    input  logic [11:0]                irq_pending,
    input  csr_pkg::priv_t             cur_priv,
    output trap_pkg::trap_req_t        trap_req
);

    trap_pkg::trap_req_t req_n;
    logic [3:0]          exc_code;
    logic [3:0]          irq_code;
    logic                irq_any;
    logic                irq_ok;

    assign exc_code = trap_id[3:0];

    // a trap already in flight will clear mie next edge, so hold off
    assign irq_ok = !(trap_req.valid && trap_req.kind == trap_pkg::EV_TRAP);

    always_comb begin
        irq_any  = 1'b1;
        irq_code = 4'd0;
        if (irq_pending[csr_pkg::BIT_MSIP])
            irq_code = 4'(csr_pkg::BIT_MSIP);
        else if (irq_pending[csr_pkg::BIT_MTIP])
            irq_code = 4'(csr_pkg::BIT_MTIP);
        else if (irq_pending[csr_pkg::BIT_MEIP])
            irq_code = 4'(csr_pkg::BIT_MEIP);
        else
            irq_any = 1'b0;
    end

    always_comb begin
        req_n      = '0;
        req_n.kind = trap_pkg::EV_TRAP;
        req_n.epc  = trap_pc;
        if (ecall) begin
            req_n.valid = 1'b1;
            req_n.code  = (cur_priv == csr_pkg::PRIV_U) ? trap_pkg::CAUSE_ECALL_U
                                                        : trap_pkg::CAUSE_ECALL_M;
        end else if (trap_id != trap_pkg::CAUSE_NONE) begin
            req_n.valid = 1'b1;
            req_n.code  = exc_code;
            case (exc_code)
                trap_pkg::CAUSE_MISALIGNED_PC,
                trap_pkg::CAUSE_ACCESS_FAULT,
                trap_pkg::CAUSE_BREAKPOINT:   req_n.tval = trap_pc;
                trap_pkg::CAUSE_ILLEGAL_INST: req_n.tval = faulting_inst; // raw bits
                default:                      req_n.tval = '0;
            endcase
        end else if (irq_ok && irq_any) begin
            req_n.valid        = 1'b1;
            req_n.is_interrupt = 1'b1;
            req_n.code         = irq_code;
        end else if (mret) begin
            req_n.valid = 1'b1;
            req_n.kind  = trap_pkg::EV_MRET;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            trap_req <= '0;
        else
            trap_req <= req_n;
    end

endmodule

`default_nettype wire

// File: hdl/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csr_ren,
    input  logic                             csr_wen,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_raddr,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_waddr,
    input  logic [csr_pkg::XLEN-1:0]         csr_wdata,
    input  logic                             msip,
    input  logic                             mtip,
    input  logic                             meip,
    input  trap_pkg::trap_req_t              trap_req,
    output logic [csr_pkg::XLEN-1:0]         csr_rdata,
    output logic [11:0]                      irq_pending,
    output csr_pkg::priv_t                   cur_priv,
    output logic [csr_pkg::XLEN-1:0]         mstatus_o,
    output trap_pkg::redirect_t              redirect
);

    logic [csr_pkg::XLEN-1:0] mstatus_r, mie_r, mip_r, mtvec_r;
    logic [csr_pkg::XLEN-1:0] mscratch_r, mepc_r, mcause_r, mtval_r;
    logic [csr_pkg::XLEN-1:0] mstatus_n, mie_n, mip_n, mtvec_n;
    logic [csr_pkg::XLEN-1:0] mscratch_n, mepc_n, mcause_n, mtval_n;
    logic [csr_pkg::XLEN-1:0] mip_lines;
    csr_pkg::priv_t           priv_r, priv_n;
    logic [1:0]               mpp;
    logic                     take_trap;
    logic                     take_mret;

    function automatic logic [csr_pkg::XLEN-1:0] merge(
        input logic [csr_pkg::XLEN-1:0] old_v,
        input logic [csr_pkg::XLEN-1:0] wr_v,
        input logic [csr_pkg::XLEN-1:0] mask
    );
        merge = (old_v & ~mask) | (wr_v & mask);
    endfunction

    assign take_trap = trap_req.valid && trap_req.kind == trap_pkg::EV_TRAP;
    assign take_mret = trap_req.valid && trap_req.kind == trap_pkg::EV_MRET;
    assign mpp       = mstatus_r[csr_pkg::BIT_MPP_LO +: 2];

    assign irq_pending = mstatus_r[csr_pkg::BIT_MIE] ? (mip_r[11:0] & mie_r[11:0]) : 12'd0;
    assign cur_priv    = priv_r;
    assign mstatus_o   = mstatus_r;

    always_comb begin
        csr_rdata = '0;
        if (csr_ren) begin
            case (csr_raddr)
                csr_pkg::ADDR_MSTATUS:  csr_rdata = mstatus_r;
                csr_pkg::ADDR_MIE:      csr_rdata = mie_r;
                csr_pkg::ADDR_MIP:      csr_rdata = mip_r;
                csr_pkg::ADDR_MTVEC:    csr_rdata = mtvec_r;
                csr_pkg::ADDR_MSCRATCH: csr_rdata = mscratch_r;
                csr_pkg::ADDR_MEPC:     csr_rdata = mepc_r;
                csr_pkg::ADDR_MCAUSE:   csr_rdata = mcause_r;
                csr_pkg::ADDR_MTVAL:    csr_rdata = mtval_r;
                default:                csr_rdata = '0; // unimplemented reads zero
            endcase
        end
    end

    always_comb begin
        mip_lines                    = '0;
        mip_lines[csr_pkg::BIT_MSIP] = msip;
        mip_lines[csr_pkg::BIT_MTIP] = mtip;
        mip_lines[csr_pkg::BIT_MEIP] = meip;

        mstatus_n  = mstatus_r;
        mie_n      = mie_r;
        mip_n      = mip_lines; // pending bits follow the lines
        mtvec_n    = mtvec_r;
        mscratch_n = mscratch_r;
        mepc_n     = mepc_r;
        mcause_n   = mcause_r;
        mtval_n    = mtval_r;
        priv_n     = priv_r;

        if (csr_wen) begin
            case (csr_waddr)
                csr_pkg::ADDR_MSTATUS:
                    mstatus_n = merge(mstatus_r, csr_wdata, csr_pkg::MASK_MSTATUS);
                csr_pkg::ADDR_MIE:
                    mie_n = merge(mie_r, csr_wdata, csr_pkg::MASK_MIE);
                csr_pkg::ADDR_MIP:
                    mip_n = merge(mip_lines, csr_wdata, csr_pkg::MASK_MIP);
                csr_pkg::ADDR_MTVEC:
                    mtvec_n = merge(mtvec_r, csr_wdata, csr_pkg::MASK_MTVEC);
                csr_pkg::ADDR_MSCRATCH:
                    mscratch_n = merge(mscratch_r, csr_wdata, csr_pkg::MASK_FULL);
                csr_pkg::ADDR_MEPC:
                    mepc_n = merge(mepc_r, csr_wdata, csr_pkg::MASK_MEPC);
                csr_pkg::ADDR_MCAUSE:
                    mcause_n = merge(mcause_r, csr_wdata, csr_pkg::MASK_FULL);
                csr_pkg::ADDR_MTVAL:
                    mtval_n = merge(mtval_r, csr_wdata, csr_pkg::MASK_FULL);
                default: ;
            endcase
        end

        // commit overrides a same-cycle write on the fields it touches
        if (take_trap) begin
            mepc_n   = trap_req.epc & csr_pkg::MASK_MEPC;
            mcause_n = {trap_req.is_interrupt, {(csr_pkg::XLEN-5){1'b0}}, trap_req.code};
            mtval_n  = trap_req.tval;
            mstatus_n[csr_pkg::BIT_MPIE]        = mstatus_r[csr_pkg::BIT_MIE];
            mstatus_n[csr_pkg::BIT_MPP_LO +: 2] = priv_r;
            mstatus_n[csr_pkg::BIT_MIE]         = 1'b0;
            priv_n   = csr_pkg::PRIV_M;
        end else if (take_mret) begin
            priv_n = (mpp == csr_pkg::PRIV_M) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
            mstatus_n[csr_pkg::BIT_MIE]         = mstatus_r[csr_pkg::BIT_MPIE];
            mstatus_n[csr_pkg::BIT_MPIE]        = 1'b1;
            mstatus_n[csr_pkg::BIT_MPP_LO +: 2] = csr_pkg::PRIV_U;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r  <= '0;
            mie_r      <= '0;
            mip_r      <= '0;
            mtvec_r    <= '0;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_r   <= '0;
            mtval_r    <= '0;
            priv_r     <= csr_pkg::PRIV_M; // boot in machine mode
            redirect   <= '0;
        end else begin
            mstatus_r      <= mstatus_n;
            mie_r          <= mie_n;
            mip_r          <= mip_n;
            mtvec_r        <= mtvec_n;
            mscratch_r     <= mscratch_n;
            mepc_r         <= mepc_n;
            mcause_r       <= mcause_n;
            mtval_r        <= mtval_n;
            priv_r         <= priv_n;
            redirect.valid <= take_trap || take_mret;
            redirect.pc    <= take_mret ? mepc_r : mtvec_r; // pre-write values
        end
    end

endmodule

`default_nettype wire

// File: hdl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csr_ren,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_raddr,
    output logic [csr_pkg::XLEN-1:0]         csr_rdata,
    input  logic                             csr_wen,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_waddr,
    input  logic [csr_pkg::XLEN-1:0]         csr_wdata,
    input  logic [csr_pkg::XLEN-1:0]         trap_pc,
    input  logic [4:0]                       trap_id,
    input  logic [csr_pkg::XLEN-1:0]         faulting_inst,
    input  logic                             ecall,
    input  logic                             mret,
    input  logic                             msip,
    input  logic                             mtip,
    input  logic                             meip,
    output trap_pkg::redirect_t              redirect,
    output csr_pkg::priv_t                   priv,
    output logic [csr_pkg::XLEN-1:0]         mstatus
);

    trap_pkg::trap_req_t trap_req;    // stage 1 to stage 2
    logic [11:0]         irq_pending; // enabled and globally unmasked
    csr_pkg::priv_t      cur_priv;

    assign priv = cur_priv;

    trap_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .trap_pc       (trap_pc),
        .faulting_inst (faulting_inst),
        .trap_id       (trap_id),
        .ecall         (ecall),
        .mret          (mret),
        .irq_pending   (irq_pending),
        .cur_priv      (cur_priv),
        .trap_req      (trap_req)
    );

    csr_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .csr_ren     (csr_ren),
        .csr_wen     (csr_wen),
        .csr_raddr   (csr_raddr),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .msip        (msip),
        .mtip        (mtip),
        .meip        (meip),
        .trap_req    (trap_req),
        .csr_rdata   (csr_rdata),
        .irq_pending (irq_pending),
        .cur_priv    (cur_priv),
        .mstatus_o   (mstatus),
        .redirect    (redirect)
    );

endmodule

`default_nettype wire

// File: tests/csr_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_properties (
    input logic                clk,
    input logic                rst,
    input trap_pkg::trap_req_t trap_req,
    input trap_pkg::redirect_t redirect
);

    // redirect is a single-cycle pulse
    redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !redirect.valid)
        else $error("redirect.valid high for two cycles in a row");

    redirect_clear_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !redirect.valid)
        else $error("redirect.valid set in the first cycle after reset");

    // stage 2 commits what stage 1 registered
    request_gives_redirect: assert property (@(posedge clk) disable iff (rst)
        trap_req.valid |=> redirect.valid)
        else $error("valid trap_req not followed by redirect");

endmodule

bind csr_unit csr_unit_properties props0 (
    .clk      (clk),
    .rst      (rst),
    .trap_req (trap_req),
    .redirect (redirect)
);

`default_nettype wire

// File: tests/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
    } step_t;

    logic                clk;
    logic                rst;
    logic                csr_ren;
    logic [11:0]         csr_raddr;
    logic [31:0]         csr_rdata;
    logic                csr_wen;
    logic [11:0]         csr_waddr;
    logic [31:0]         csr_wdata;
    logic [31:0]         trap_pc;
    logic [4:0]          trap_id;
    logic [31:0]         faulting_inst;
    logic                ecall;
    logic                mret;
    logic                msip;
    logic                mtip;
    logic                meip;
    trap_pkg::redirect_t redirect;
    csr_pkg::priv_t      priv;
    logic [31:0]         mstatus;

    string ops[$];
    step_t steps[$];
    int    errors;
    int    checks;
    int    cycles;
    int    limit;

    csr_unit dut0 (
        .clk(clk), .rst(rst),
        .csr_ren(csr_ren), .csr_raddr(csr_raddr), .csr_rdata(csr_rdata),
        .csr_wen(csr_wen), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
        .trap_pc(trap_pc), .trap_id(trap_id), .faulting_inst(faulting_inst),
        .ecall(ecall), .mret(mret), .msip(msip), .mtip(mtip), .meip(meip),
        .redirect(redirect), .priv(priv), .mstatus(mstatus)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic clear_strobes();
        ecall   <= 1'b0;
        mret    <= 1'b0;
        csr_wen <= 1'b0;
        trap_id <= trap_pkg::CAUSE_NONE;
    endtask

    task automatic write_csr(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_wen   <= 1'b1;
        csr_waddr <= addr[11:0];
        csr_wdata <= data;
        @(posedge clk);
        csr_wen <= 1'b0;
    endtask

    task automatic read_csr(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        csr_ren   <= 1'b1;
        csr_raddr <= addr[11:0];
        @(negedge clk); // combinational read settles here
        check_value($sformatf("csr_rdata[%h]", addr[11:0]), exp, csr_rdata);
        if (addr[11:0] == csr_pkg::ADDR_MSTATUS)
            check_value("mstatus", exp, mstatus); // output port mirrors the register
    endtask

    // strobe already driven; count edges until redirect shows up
    task automatic await_redirect(input int lim, input int exact, input logic [31:0] exp_pc,
                                  input int quiet);
        int edges;
        bit seen;
        edges = 0;
        seen  = 0;
        while (!seen && edges < lim) begin
            @(posedge clk);
            edges++;
            clear_strobes();
            @(negedge clk);
            if (redirect.valid)
                seen = 1;
        end
        if (!seen) begin
            errors++;
            $display("no redirect within %0d cycles, at time %0t", lim, $time);
        end else begin
            check_value("redirect.pc", exp_pc, redirect.pc);
            if (exact != 0)
                check_value("redirect latency", exact, edges);
            repeat (quiet) begin
                @(posedge clk);
                @(negedge clk);
                check_value("redirect.valid", 0, redirect.valid); // no second take
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          ch;
        string       op;
        logic [31:0] a, b, c, d;
        step_t       s;
        clk           = 0;
        rst           = 1;
        csr_ren       = 0;
        csr_raddr     = '0;
        csr_wen       = 0;
        csr_waddr     = '0;
        csr_wdata     = '0;
        trap_pc       = '0;
        trap_id       = trap_pkg::CAUSE_NONE;
        faulting_inst = '0;
        ecall         = 0;
        mret          = 0;
        msip          = 0;
        mtip          = 0;
        meip          = 0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        limit         = 10;

        fd = $fopen("tests/csr_unit_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/csr_unit_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", op);
                if (n != 1)
                    break;
                if (op.substr(0, 0) == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd); // skip comment to end of line
                end else begin
                    n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    if (n != 4) begin
                        errors++;
                        $display("malformed test line for op %s", op);
                    end else begin
                        ops.push_back(op);
                        steps.push_back({a, b, c, d});
                    end
                end
            end
            $fclose(fd);
        end
        limit = 10 + 20 * ops.size();

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        foreach (ops[i]) begin
            s = steps[i];
            case (ops[i])
                "WR": write_csr(s.a, s.b);
                "RD": read_csr(s.a, s.b);
                "EXC": begin
                    @(posedge clk);
                    trap_id       <= s.a[4:0];
                    trap_pc       <= s.b;
                    faulting_inst <= s.c;
                    await_redirect(4, 2, s.d, 1);
                end
                "ECALL": begin
                    @(posedge clk);
                    ecall   <= 1'b1;
                    trap_pc <= s.a;
                    await_redirect(4, 2, s.b, 1);
                end
                "MRET": begin
                    @(posedge clk);
                    mret <= 1'b1;
                    await_redirect(4, 2, s.a, 1);
                end
                "IRQ": begin
                    @(posedge clk);
                    msip    <= s.a[3];
                    mtip    <= s.a[7];
                    meip    <= s.a[11];
                    trap_pc <= s.b;
                    await_redirect(5, 0, s.c, 8); // lines stay high afterwards
                end
                "LINES": begin
                    @(posedge clk);
                    msip <= s.a[3];
                    mtip <= s.a[7];
                    meip <= s.a[11];
                end
                "PRIV": begin
                    @(negedge clk);
                    check_value("priv", s.a, priv);
                end
                default: begin
                    errors++;
                    $display("unknown op %s in test file", ops[i]);
                end
            endcase
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/csr_unit_tests.txt
# op f0 f1 f2 f3, all hex, unused columns 0; WR addr data, RD addr expect, PRIV expect
# EXC id pc inst redirect_pc, ECALL pc redirect_pc, MRET redirect_pc, IRQ lines pc redirect_pc
WR    300 ffffffff 0 0
RD    300 00001888 0 0
WR    304 ffffffff 0 0
RD    304 00000888 0 0
WR    305 ffffffff 0 0
RD    305 fffffffc 0 0
WR    341 ffffffff 0 0
RD    341 fffffffc 0 0
WR    340 ffffffff 0 0
RD    340 ffffffff 0 0
WR    344 ffffffff 0 0
RD    344 00000000 0 0
RD    7c0 00000000 0 0
WR    305 00000100 0 0
ECALL 00002000 00000100 0 0
RD    341 00002000 0 0
RD    342 0000000b 0 0
RD    343 00000000 0 0
RD    300 00001880 0 0
PRIV  3 0 0 0
EXC   2 00002004 deadbeef 00000100
RD    342 00000002 0 0
RD    343 deadbeef 0 0
EXC   0 00002006 00000000 00000100
RD    341 00002004 0 0
RD    343 00002006 0 0
WR    300 00000080 0 0
WR    341 00003000 0 0
MRET  00003000 0 0 0
PRIV  0 0 0 0
RD    300 00000088 0 0
ECALL 00003004 00000100 0 0
RD    342 00000008 0 0
PRIV  3 0 0 0
WR    304 00000080 0 0
WR    300 00000008 0 0
IRQ   00000080 00004000 00000100 0
RD    342 80000007 0 0
RD    300 00001880 0 0
RD    341 00004000 0 0
RD    344 00000080 0 0
LINES 0 0 0 0
RD    344 00000000 0 0

// File: sources.f
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/trap_arbiter.sv
hdl/csr_regs.sv
hdl/csr_unit.sv
tests/csr_unit_properties.sv
tests/csr_unit_tb.sv
